/* hw/cpu_queue_macros.svh */
// CPU queue parameters and register map
`ifndef CPU_QUEUE_MACROS_SVH
`define CPU_QUEUE_MACROS_SVH

// word and field widths
`define CPU_DATA_WIDTH          32
`define CPU_CTRL_WIDTH          4    // one bit per byte
`define CPU_REG_ADDR_WIDTH      4

// queue sizing
`define FIFO_DEPTH              512
`define FIFO_ALMOST_FULL_MARGIN 12   // free slots kept back for in-flight words

// register map
`define REG_RD_CTRL_WORD        4'd0
`define REG_RD_DATA_WORD        4'd1
`define REG_WR_CTRL_WORD        4'd2
`define REG_WR_DATA_WORD        4'd3
`define REG_RX_NUM_PKTS_RCVD    4'd4
`define REG_TX_NUM_PKTS_SENT    4'd5
`define REG_WR_NUM_PKTS_IN_Q    4'd6
`define REG_WR_NUM_WORDS_LEFT   4'd7
`define REG_RD_NUM_PKTS_IN_Q    4'd8
`define REG_RD_NUM_WORDS_AVAIL  4'd9

`endif

/* hw/cpu_queue_pkg.sv */
// CPU queue shared types
`include "cpu_queue_macros.svh"

package cpu_queue_pkg;

   // one data path word
   typedef logic [`CPU_DATA_WIDTH-1:0]     word_t;

   // per-byte control, nonzero marks the last word
   typedef logic [`CPU_CTRL_WIDTH-1:0]     ctrl_t;

   typedef logic [`CPU_REG_ADDR_WIDTH-1:0] reg_addr_t;

   // register-wide counter
   typedef logic [`CPU_DATA_WIDTH-1:0]     count_t;

   // fifo occupancy, must reach FIFO_DEPTH itself
   typedef logic [$clog2(`FIFO_DEPTH+1)-1:0] level_t;

endpackage

/* hw/rx_pop_if.sv */
// Receive queue pop interface
`timescale 1ns/1ns

interface rx_pop_if import cpu_queue_pkg::*; ();

   logic   pop;          // one-cycle strobe from the register block
   word_t  head_data;    // fifo head, already in cpu byte order
   ctrl_t  head_ctrl;
   logic   empty;
   count_t pkts_in_q;
   level_t words_avail;
   logic   pkt_popped;   // last word of a packet left the queue

   modport cpu (
      output pop,
      input  head_data, head_ctrl, empty, pkts_in_q, words_avail, pkt_popped
   );

   modport queue (
      input  pop,
      output head_data, head_ctrl, empty, pkts_in_q, words_avail, pkt_popped
   );

endinterface

/* hw/tx_push_if.sv */
// Transmit queue push interface
`timescale 1ns/1ns

interface tx_push_if import cpu_queue_pkg::*; ();

   logic   push;         // one-cycle strobe
   word_t  push_data;
   ctrl_t  push_ctrl;    // held in the WR_CTRL_WORD register
   logic   full;
   count_t pkts_in_q;    // complete packets only
   level_t words_left;
   logic   pkt_sent;     // last word went out on the data path

   modport cpu (
      output push, push_data, push_ctrl,
      input  full, pkts_in_q, words_left, pkt_sent
   );

   modport queue (
      input  push, push_data, push_ctrl,
      output full, pkts_in_q, words_left, pkt_sent
   );

endinterface

/* hw/fwft_fifo.sv */
// First-word-fall-through FIFO
`timescale 1ns/1ns
`include "cpu_queue_macros.svh"

module fwft_fifo import cpu_queue_pkg::*; #(
   parameter int WIDTH = `CPU_DATA_WIDTH + `CPU_CTRL_WIDTH,
   parameter int DEPTH = `FIFO_DEPTH   // power of two
) (
   input  logic             clk,
   input  logic             reset,
   input  logic             wr_en,
   input  logic [WIDTH-1:0] din,
   input  logic             rd_en,
   output logic [WIDTH-1:0] dout,
   output logic             empty,
   output logic             full,
   output level_t           level
);

   localparam int PTR_WIDTH = $clog2(DEPTH);

   logic [WIDTH-1:0]     mem [DEPTH];
   logic [PTR_WIDTH-1:0] wr_ptr;
   logic [PTR_WIDTH-1:0] rd_ptr;
   logic                 wr_ok;
   logic                 rd_ok;

   assign empty = (level == '0);
   assign full  = (level == level_t'(DEPTH));
   assign wr_ok = wr_en && !full;    // overflow words are lost
   assign rd_ok = rd_en && !empty;

   // head word always visible
   assign dout = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (wr_ok) begin
         mem[wr_ptr] <= din;
      end
   end

   ////////////////////////////////
   // pointers and occupancy
   ////////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         level  <= '0;
      end else begin
         if (wr_ok) begin
            wr_ptr <= wr_ptr + 1'b1;    // wraps at DEPTH
         end
         if (rd_ok) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({wr_ok, rd_ok})
            2'b10:   level <= level + 1'b1;
            2'b01:   level <= level - 1'b1;
            default: level <= level;     // idle or both
         endcase
      end
   end

endmodule

/* hw/rx_queue.sv */
// Receive packet queue
`timescale 1ns/1ns
`include "cpu_queue_macros.svh"

module rx_queue import cpu_queue_pkg::*; (
   input  logic     clk,
   input  logic     reset,
   input  word_t    in_data,
   input  ctrl_t    in_ctrl,
   input  logic     in_wr,
   output logic     in_rdy,
   rx_pop_if.queue  pop_if
);

   word_t  swapped_data;
   ctrl_t  swapped_ctrl;
   logic   fifo_empty;
   logic   fifo_full;
   level_t fifo_level;
   logic   pkt_written;
   count_t pkts_in_q;

   // data path is big endian, cpu wants little endian
   assign swapped_data = {<<8{in_data}};
   assign swapped_ctrl = {<<{in_ctrl}};     // bit order follows the bytes

   fwft_fifo #(
      .WIDTH (`CPU_CTRL_WIDTH + `CPU_DATA_WIDTH),
      .DEPTH (`FIFO_DEPTH)
   ) rx_fifo (
      .clk   (clk),
      .reset (reset),
      .wr_en (in_wr),
      .din   ({swapped_ctrl, swapped_data}),
      .rd_en (pop_if.pop),
      .dout  ({pop_if.head_ctrl, pop_if.head_data}),
      .empty (fifo_empty),
      .full  (fifo_full),
      .level (fifo_level)
   );

   // back-pressure with margin left for words already on the way
   assign in_rdy = (level_t'(`FIFO_DEPTH) - fifo_level)
                   >= level_t'(`FIFO_ALMOST_FULL_MARGIN);

   assign pkt_written       = in_wr && !fifo_full && (|in_ctrl);
   assign pop_if.pkt_popped = pop_if.pop && !fifo_empty && (|pop_if.head_ctrl);

   always_ff @(posedge clk) begin
      if (reset) begin
         pkts_in_q <= '0;
      end else begin
         case ({pkt_written, pop_if.pkt_popped})
            2'b10:   pkts_in_q <= pkts_in_q + 1'b1;
            2'b01:   pkts_in_q <= pkts_in_q - 1'b1;
            default: pkts_in_q <= pkts_in_q;
         endcase
      end
   end

   assign pop_if.empty       = fifo_empty;
   assign pop_if.pkts_in_q   = pkts_in_q;
   assign pop_if.words_avail = fifo_level;

endmodule

/* hw/tx_queue.sv */
// Transmit packet queue
`timescale 1ns/1ns
`include "cpu_queue_macros.svh"

module tx_queue import cpu_queue_pkg::*; (
   input  logic     clk,
   input  logic     reset,
   input  logic     out_rdy,
   output word_t    out_data,
   output ctrl_t    out_ctrl,
   output logic     out_wr,
   tx_push_if.queue push_if
);

   word_t  head_data;
   ctrl_t  head_ctrl;
   logic   fifo_empty;
   logic   fifo_full;
   level_t fifo_level;
   logic   pkt_written;
   logic   rd_en;
   count_t pkts_in_q;

   // cpu side words stored in little endian
   fwft_fifo #(
      .WIDTH (`CPU_CTRL_WIDTH + `CPU_DATA_WIDTH),
      .DEPTH (`FIFO_DEPTH)
   ) tx_fifo (
      .clk   (clk),
      .reset (reset),
      .wr_en (push_if.push),
      .din   ({push_if.push_ctrl, push_if.push_data}),
      .rd_en (rd_en),
      .dout  ({head_ctrl, head_data}),
      .empty (fifo_empty),
      .full  (fifo_full),
      .level (fifo_level)
   );

   ////////////////////////////////
   // output streaming
   ////////////////////////////////
   // only whole packets go out, so the fifo is never empty here
   assign rd_en  = (pkts_in_q != '0) && out_rdy && !fifo_empty;
   assign out_wr = rd_en;

   // back to data path byte order
   assign out_data = {<<8{head_data}};
   assign out_ctrl = {<<{head_ctrl}};

   assign pkt_written      = push_if.push && !fifo_full && (|push_if.push_ctrl);
   assign push_if.pkt_sent = rd_en && (|head_ctrl);

   // complete packets waiting in the fifo
   always_ff @(posedge clk) begin
      if (reset) begin
         pkts_in_q <= '0;
      end else begin
         case ({pkt_written, push_if.pkt_sent})
            2'b10:   pkts_in_q <= pkts_in_q + 1'b1;
            2'b01:   pkts_in_q <= pkts_in_q - 1'b1;
            default: pkts_in_q <= pkts_in_q;
         endcase
      end
   end

   assign push_if.full       = fifo_full;
   assign push_if.pkts_in_q  = pkts_in_q;
   assign push_if.words_left = level_t'(`FIFO_DEPTH) - fifo_level;

endmodule

/* hw/cpu_reg_access.sv */
// CPU register access block
`timescale 1ns/1ns
`include "cpu_queue_macros.svh"

module cpu_reg_access import cpu_queue_pkg::*; (
   input  logic      clk,
   input  logic      reset,
   input  logic      reg_req,
   input  logic      reg_rd_wr_l,
   input  reg_addr_t reg_addr,
   input  word_t     reg_wr_data,
   output word_t     reg_rd_data,
   output logic      reg_ack,
   rx_pop_if.cpu     rx_if,
   tx_push_if.cpu    tx_if
);

   logic   req_d1;
   logic   access;       // first cycle of a request
   logic   rd_access;
   logic   wr_access;
   word_t  rd_value;
   ctrl_t  rd_ctrl;      // control of the last popped word
   ctrl_t  wr_ctrl;      // control applied to pushed words
   count_t rx_pkts_rcvd;
   count_t tx_pkts_sent;

   assign access    = reg_req && !req_d1;
   assign rd_access = access && reg_rd_wr_l;
   assign wr_access = access && !reg_rd_wr_l;

   // queue strobes fire on the access cycle itself
   assign rx_if.pop       = rd_access && (reg_addr == `REG_RD_DATA_WORD);
   assign tx_if.push      = wr_access && (reg_addr == `REG_WR_DATA_WORD) && !tx_if.full;
   assign tx_if.push_data = reg_wr_data;
   assign tx_if.push_ctrl = wr_ctrl;

   ////////////////////////////////
   // read mux
   ////////////////////////////////
   always_comb begin
      rd_value = '0;     // unmapped and write cycles return zero
      if (rd_access) begin
         case (reg_addr)
            `REG_RD_CTRL_WORD:       rd_value = word_t'(rd_ctrl);
            `REG_RD_DATA_WORD:       rd_value = rx_if.empty ? '0 : rx_if.head_data;
            `REG_WR_CTRL_WORD:       rd_value = word_t'(wr_ctrl);
            `REG_RX_NUM_PKTS_RCVD:   rd_value = rx_pkts_rcvd;
            `REG_TX_NUM_PKTS_SENT:   rd_value = tx_pkts_sent;
            `REG_WR_NUM_PKTS_IN_Q:   rd_value = tx_if.pkts_in_q;
            `REG_WR_NUM_WORDS_LEFT:  rd_value = word_t'(tx_if.words_left);
            `REG_RD_NUM_PKTS_IN_Q:   rd_value = rx_if.pkts_in_q;
            `REG_RD_NUM_WORDS_AVAIL: rd_value = word_t'(rx_if.words_avail);
            default:                 rd_value = '0;
         endcase
      end
   end

   ////////////////////////////////
   // handshake and registers
   ////////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         req_d1       <= 1'b0;
         reg_ack      <= 1'b0;
         reg_rd_data  <= '0;
         rd_ctrl      <= '0;
         wr_ctrl      <= '0;
         rx_pkts_rcvd <= '0;
         tx_pkts_sent <= '0;
      end else begin
         req_d1  <= reg_req;
         reg_ack <= access;     // exactly one cycle per request
         if (access) begin
            reg_rd_data <= rd_value;
         end

         // pop also latches the control that came with the word
         if (rx_if.pop && !rx_if.empty) begin
            rd_ctrl <= rx_if.head_ctrl;
         end
         if (wr_access && reg_addr == `REG_WR_CTRL_WORD) begin
            wr_ctrl <= reg_wr_data[`CPU_CTRL_WIDTH-1:0];
         end

         // cpu write wins over a count pulse
         if (wr_access && reg_addr == `REG_RX_NUM_PKTS_RCVD) begin
            rx_pkts_rcvd <= reg_wr_data;
         end else begin
            rx_pkts_rcvd <= rx_pkts_rcvd + count_t'(rx_if.pkt_popped);
         end
         if (wr_access && reg_addr == `REG_TX_NUM_PKTS_SENT) begin
            tx_pkts_sent <= reg_wr_data;
         end else begin
            tx_pkts_sent <= tx_pkts_sent + count_t'(tx_if.pkt_sent);
         end
      end
   end

endmodule

/* hw/cpu_reg_queue.sv */
// CPU packet queue top level
`timescale 1ns/1ns

module cpu_reg_queue import cpu_queue_pkg::*; (
   input  logic      clk,
   input  logic      reset,

   // data path in
   input  word_t     in_data,
   input  ctrl_t     in_ctrl,
   input  logic      in_wr,
   output logic      in_rdy,

   // data path out
   output word_t     out_data,
   output ctrl_t     out_ctrl,
   output logic      out_wr,
   input  logic      out_rdy,

   // cpu register bus
   input  logic      reg_req,
   input  logic      reg_rd_wr_l,
   input  reg_addr_t reg_addr,
   input  word_t     reg_wr_data,
   output word_t     reg_rd_data,
   output logic      reg_ack
);

   rx_pop_if  rx_pop ();
   tx_push_if tx_push ();

   rx_queue u_rx_queue (
      .clk     (clk),
      .reset   (reset),
      .in_data (in_data),
      .in_ctrl (in_ctrl),
      .in_wr   (in_wr),
      .in_rdy  (in_rdy),
      .pop_if  (rx_pop.queue)
   );

   tx_queue u_tx_queue (
      .clk      (clk),
      .reset    (reset),
      .out_rdy  (out_rdy),
      .out_data (out_data),
      .out_ctrl (out_ctrl),
      .out_wr   (out_wr),
      .push_if  (tx_push.queue)
   );

   cpu_reg_access u_cpu_reg_access (
      .clk         (clk),
      .reset       (reset),
      .reg_req     (reg_req),
      .reg_rd_wr_l (reg_rd_wr_l),
      .reg_addr    (reg_addr),
      .reg_wr_data (reg_wr_data),
      .reg_rd_data (reg_rd_data),
      .reg_ack     (reg_ack),
      .rx_if       (rx_pop.cpu),
      .tx_if       (tx_push.cpu)
   );

endmodule

/* dv/cpu_reg_queue_checker.sv */
// CPU queue protocol assertions
`timescale 1ns/1ns

module cpu_reg_queue_checker (
   input logic clk,
   input logic reset,
   input logic reg_req,
   input logic reg_ack,
   input logic out_wr,
   input logic out_rdy
);

   // ack is a single-cycle pulse
   ack_one_cycle: assert property (@(posedge clk) disable iff (reset)
      reg_ack |=> !reg_ack)
      else $error("reg_ack high on two consecutive cycles");

   out_wr_needs_rdy: assert property (@(posedge clk) disable iff (reset)
      out_wr |-> out_rdy)
      else $error("out_wr asserted while out_rdy low");

   // one cycle from new request to ack, and no ack without a request
   ack_after_req: assert property (@(posedge clk) disable iff (reset)
      $rose(reg_req) |=> reg_ack)
      else $error("reg_ack missing one cycle after reg_req rose");

   ack_has_req: assert property (@(posedge clk) disable iff (reset)
      reg_ack |-> $past(reg_req))
      else $error("reg_ack without a preceding reg_req");

endmodule

bind cpu_reg_queue cpu_reg_queue_checker u_checker (
   .clk     (clk),
   .reset   (reset),
   .reg_req (reg_req),
   .reg_ack (reg_ack),
   .out_wr  (out_wr),
   .out_rdy (out_rdy)
);

/* dv/cpu_reg_queue_tb.sv */
// CPU packet queue testbench
`timescale 1ns/1ns
`include "cpu_queue_macros.svh"

module cpu_reg_queue_tb import cpu_queue_pkg::*; ();

   localparam int CLK_PERIOD      = 10;
   localparam int RESET_CYCLES    = 8;
   localparam int NUM_TESTS       = 5;
   localparam int WORDS_PER_TEST  = 12;   // register accesses plus data words
   localparam int CYCLES_PER_WORD = 6;
   localparam int TIMEOUT_CYCLES  =
      2 * (RESET_CYCLES + NUM_TESTS * WORDS_PER_TEST * CYCLES_PER_WORD);

   logic      clk;
   logic      reset;
   word_t     in_data;
   ctrl_t     in_ctrl;
   logic      in_wr;
   logic      in_rdy;
   word_t     out_data;
   ctrl_t     out_ctrl;
   logic      out_wr;
   logic      out_rdy;
   logic      reg_req;
   logic      reg_rd_wr_l;
   reg_addr_t reg_addr;
   word_t     reg_wr_data;
   word_t     reg_rd_data;
   logic      reg_ack;

   word_t     exp_data [$];   // expected output words in order
   ctrl_t     exp_ctrl [$];

   cpu_reg_queue UUT (.*);

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      #(TIMEOUT_CYCLES * CLK_PERIOD);
      $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      stop_run();
   end

   //////////////////////////////
   // reporting and compares
   //////////////////////////////
   task automatic stop_run();
      $display("Errors found");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic check_word(input word_t got, input word_t exp, input string what);
      if (got !== exp) begin
         $display("ERR %0t ns: %s is %h, expected %h", $time, what, got, exp);
         stop_run();
      end
   endtask

   task automatic check_ctrl(input ctrl_t got, input ctrl_t exp, input string what);
      if (got !== exp) begin
         $display("ERR %0t ns: %s is %b, expected %b", $time, what, got, exp);
         stop_run();
      end
   endtask

   task automatic check_count(input count_t got, input count_t exp, input string what);
      if (got !== exp) begin
         $display("ERR %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
         stop_run();
      end
   endtask

   // data path order is big endian, cpu order little endian
   function automatic word_t byte_reverse(input word_t w);
      return {w[7:0], w[15:8], w[23:16], w[31:24]};
   endfunction

   function automatic ctrl_t bit_reverse(input ctrl_t c);
      return {c[0], c[1], c[2], c[3]};
   endfunction

   function automatic ctrl_t random_last_ctrl();
      return ctrl_t'(4'b0001 << ($urandom % 4));   // one-hot byte position
   endfunction

   //////////////////////////////
   // register bus
   //////////////////////////////
   task automatic bus_cycle(input logic rd, input reg_addr_t addr, input word_t wdata,
                            output word_t rdata);
      @(negedge clk);
      reg_req     = 1'b1;
      reg_rd_wr_l = rd;
      reg_addr    = addr;
      reg_wr_data = wdata;
      do begin
         @(negedge clk);
      end while (!reg_ack);
      rdata   = reg_rd_data;
      reg_req = 1'b0;   // low for at least the next rising edge
   endtask

   task automatic reg_write(input reg_addr_t addr, input word_t data);
      word_t ignored;
      bus_cycle(1'b0, addr, data, ignored);
   endtask

   task automatic reg_read(input reg_addr_t addr, output word_t data);
      bus_cycle(1'b1, addr, '0, data);
   endtask

   task automatic read_and_check(input reg_addr_t addr, input count_t exp, input string what);
      word_t v;
      reg_read(addr, v);
      check_count(count_t'(v), exp, what);
   endtask

   // cpu side packet with its expected output queued in data path order
   task automatic push_tx_packet(input int n);
      word_t d;
      ctrl_t last;
      last = random_last_ctrl();
      reg_write(`REG_WR_CTRL_WORD, '0);
      for (int i = 0; i < n; i++) begin
         d = $urandom;
         if (i == n - 1) begin
            check_count(count_t'(out_wr), '0, "out_wr before last word");
            reg_write(`REG_WR_CTRL_WORD, word_t'(last));
         end
         reg_write(`REG_WR_DATA_WORD, d);
         exp_data.push_back(byte_reverse(d));
         exp_ctrl.push_back((i == n - 1) ? bit_reverse(last) : '0);
      end
   endtask

   task automatic collect_tx(input int n, input bit toggle);
      int cycle;
      int got;
      cycle = 0;
      got   = 0;
      while (got < n) begin
         @(negedge clk);
         out_rdy = toggle ? cycle[0] : 1'b1;
         cycle++;
         #1;   // let out_wr settle after out_rdy changes
         if (out_wr) begin
            check_word(out_data, exp_data.pop_front(), "out_data");
            check_ctrl(out_ctrl, exp_ctrl.pop_front(), "out_ctrl");
            got++;
         end
      end
   endtask

   //////////////////////////////
   // directed tests
   //////////////////////////////
   task automatic test_reset_values();
      int a;
      check_count(count_t'(in_rdy), 1, "in_rdy after reset");
      for (a = 0; a < 10; a++) begin
         read_and_check(reg_addr_t'(a),
                        (reg_addr_t'(a) == `REG_WR_NUM_WORDS_LEFT) ? count_t'(`FIFO_DEPTH) : '0,
                        $sformatf("register %0d after reset", a));
      end
   endtask

   task automatic test_receive_path();
      word_t words [3];
      word_t v;
      ctrl_t last;
      int    i;
      last = random_last_ctrl();
      for (i = 0; i < 3; i++) begin
         words[i] = $urandom;
         @(negedge clk);
         in_data = words[i];
         in_ctrl = (i == 2) ? last : '0;
         in_wr   = 1'b1;
      end
      @(negedge clk);
      in_wr = 1'b0;
      read_and_check(`REG_RD_NUM_WORDS_AVAIL, 3, "rx words available");
      read_and_check(`REG_RD_NUM_PKTS_IN_Q, 1, "rx packets in queue");
      for (i = 0; i < 3; i++) begin
         reg_read(`REG_RD_DATA_WORD, v);
         check_word(v, byte_reverse(words[i]), $sformatf("rx word %0d", i));
      end
      reg_read(`REG_RD_CTRL_WORD, v);
      check_ctrl(ctrl_t'(v), bit_reverse(last), "rx last control");
      read_and_check(`REG_RX_NUM_PKTS_RCVD, 1, "packets received");
      read_and_check(`REG_RD_NUM_WORDS_AVAIL, 0, "rx words after pops");
      read_and_check(`REG_RD_NUM_PKTS_IN_Q, 0, "rx packets after pops");
   endtask

   task automatic test_transmit_path();
      out_rdy = 1'b0;
      push_tx_packet(3);
      read_and_check(`REG_WR_NUM_WORDS_LEFT, `FIFO_DEPTH - 3, "tx words left");
      read_and_check(`REG_WR_NUM_PKTS_IN_Q, 1, "tx packets in queue");
      collect_tx(3, 1'b0);
      read_and_check(`REG_TX_NUM_PKTS_SENT, 1, "packets sent");
      read_and_check(`REG_WR_NUM_WORDS_LEFT, `FIFO_DEPTH, "tx words left after send");
   endtask

   task automatic test_back_pressure();
      out_rdy = 1'b0;
      push_tx_packet(4);
      collect_tx(4, 1'b1);
      // an extra or repeated word would leave the queue short
      read_and_check(`REG_WR_NUM_WORDS_LEFT, `FIFO_DEPTH, "tx words left after toggling");
      read_and_check(`REG_WR_NUM_PKTS_IN_Q, 0, "tx packets after toggling");
      read_and_check(`REG_TX_NUM_PKTS_SENT, 2, "packets sent after toggling");
   endtask

   task automatic test_counter_override();
      word_t v;
      reg_write(`REG_RX_NUM_PKTS_RCVD, 100);
      read_and_check(`REG_RX_NUM_PKTS_RCVD, 100, "packets received override");
      reg_read(`REG_RD_DATA_WORD, v);   // queue is empty here
      check_word(v, '0, "pop from empty rx queue");
      read_and_check(`REG_RD_NUM_WORDS_AVAIL, 0, "rx words after empty pop");
   endtask

   initial begin
      reset       = 1'b1;
      in_data     = '0;
      in_ctrl     = '0;
      in_wr       = 1'b0;
      out_rdy     = 1'b0;
      reg_req     = 1'b0;
      reg_rd_wr_l = 1'b1;
      reg_addr    = '0;
      reg_wr_data = '0;
      void'($urandom(48157));
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      test_reset_values();
      test_receive_path();
      test_transmit_path();
      test_back_pressure();
      test_counter_override();

      $display("No errors");
      $finish;
   end

endmodule

/* vlog.f */
+incdir+hw
hw/cpu_queue_pkg.sv
hw/rx_pop_if.sv
hw/tx_push_if.sv
hw/fwft_fifo.sv
hw/rx_queue.sv
hw/tx_queue.sv
hw/cpu_reg_access.sv
hw/cpu_reg_queue.sv
dv/cpu_reg_queue_checker.sv
dv/cpu_reg_queue_tb.sv

/* Makefile */
BIN := obj_dir/Vcpu_reg_queue_tb

all: run

$(BIN): vlog.f $(wildcard hw/*.sv hw/*.svh dv/*.sv)
	verilator --binary --timing --assert --top-module cpu_reg_queue_tb -f vlog.f

run: $(BIN)
	./$(BIN) | tee sim.log
	grep -qx "No errors" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
